//--- design/definitions.sv
package definitions;

    parameter int XLEN = 32;

    // addi x0, x0, 0
    parameter logic [31:0] NOP_INSTR = 32'h0000_0013;

    typedef logic [4:0] regName_t;

    typedef enum logic [2:0] {
        alu_add    = 3'd0,
        alu_sub    = 3'd1,
        alu_and    = 3'd2,
        alu_or     = 3'd3,
        alu_xor    = 3'd4,
        alu_slt    = 3'd5,
        alu_pass_b = 3'd6      // LUI and link values
    } alu_op_t;

    // Major opcodes handled by the decoder
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_lui    = 7'b0110111,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111
    } opcode_t;

endpackage : definitions

//--- design/hazard_unit.sv
module hazard_unit import definitions::*; (
    input  logic     clk,
    input  logic     rstN,
    input  regName_t rs1_id,
    input  regName_t rs2_id,
    input  regName_t rd_ex,
    input  logic     branch_cu,
    input  logic     jump_reg_cu,
    input  logic     ex_mem_read,
    input  logic     ex_mem_write,
    input  logic     mem_ready,
    input  logic     reg_write_ex,
    output logic     if_id_write,
    output logic     pc_write,
    output logic     id_ex_hold,
    output logic     id_ex_bubble,
    output logic     branch_go,
    output logic     jump_reg_go,
    output logic     mem_done
);

    typedef enum logic [2:0] {
        idle             = 3'd0,
        before_read_mem  = 3'd1,
        read_mem         = 3'd2,
        before_write_mem = 3'd3,
        write_mem        = 3'd4
    } state_t;

    state_t state, next_state;

    logic ex_writes_rd;
    logic branch_stall, jump_reg_stall, reg_stall, mem_stall;

    assign ex_writes_rd = reg_write_ex && (rd_ex != '0);

    // Branch and JALR compare in ID, so an EX result cannot reach them in time
    assign branch_stall   = branch_cu && ex_writes_rd && (rs1_id == rd_ex || rs2_id == rd_ex);
    assign jump_reg_stall = jump_reg_cu && ex_writes_rd && (rs1_id == rd_ex);
    assign reg_stall      = branch_stall || jump_reg_stall;

    assign mem_done  = (state == read_mem || state == write_mem) && mem_ready;
    assign mem_stall = (state != idle || ex_mem_read || ex_mem_write) && !mem_done;

    assign pc_write     = !(mem_stall || reg_stall);
    assign if_id_write  = !(mem_stall || reg_stall);
    assign id_ex_hold   = mem_stall;
    assign id_ex_bubble = reg_stall && !mem_stall;   // EX moves on, ID waits

    assign branch_go   = branch_cu && !branch_stall && !mem_stall;
    assign jump_reg_go = jump_reg_cu && !jump_reg_stall && !mem_stall;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                if (ex_mem_read) begin
                    next_state = before_read_mem;
                end else if (ex_mem_write) begin
                    next_state = before_write_mem;
                end
            end
            before_read_mem: begin
                if (!mem_ready) next_state = read_mem;     // Memory took the request
            end
            read_mem: begin
                if (mem_ready) next_state = idle;
            end
            before_write_mem: begin
                if (!mem_ready) next_state = write_mem;
            end
            write_mem: begin
                if (mem_ready) next_state = idle;
            end
            default: next_state = idle;
        endcase
    end

endmodule : hazard_unit

//--- design/control_unit.sv
module control_unit import definitions::*; (
    input  logic [31:0]     instr,
    output regName_t        rs1,
    output regName_t        rs2,
    output regName_t        rd,
    output alu_op_t         alu_op,
    output logic            alu_src_imm,
    output logic            reg_write,
    output logic            mem_read,
    output logic            mem_write,
    output logic            branch,
    output logic            branch_ne,
    output logic            jump,
    output logic            jump_reg,
    output logic [31:0]     imm
);

    logic [2:0] funct3;
    logic [6:0] funct7;

    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        alu_op      = alu_add;
        alu_src_imm = 1'b0;
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        branch      = 1'b0;
        branch_ne   = 1'b0;
        jump        = 1'b0;
        jump_reg    = 1'b0;
        imm         = '0;

        case (instr[6:0])
            opc_op: begin
                reg_write = 1'b1;
                case ({funct7, funct3})
                    {7'b0000000, 3'b000}: alu_op = alu_add;
                    {7'b0100000, 3'b000}: alu_op = alu_sub;
                    {7'b0000000, 3'b111}: alu_op = alu_and;
                    {7'b0000000, 3'b110}: alu_op = alu_or;
                    {7'b0000000, 3'b100}: alu_op = alu_xor;
                    {7'b0000000, 3'b010}: alu_op = alu_slt;
                    default: reg_write = 1'b0;
                endcase
            end
            opc_op_imm: begin
                if (funct3 == 3'b000) begin     // ADDI only
                    reg_write   = 1'b1;
                    alu_src_imm = 1'b1;
                    imm         = {{20{instr[31]}}, instr[31:20]};
                end
            end
            opc_lui: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = alu_pass_b;
                imm         = {instr[31:12], 12'b0};
            end
            opc_load: begin
                if (funct3 == 3'b010) begin
                    reg_write   = 1'b1;
                    mem_read    = 1'b1;
                    alu_src_imm = 1'b1;
                    imm         = {{20{instr[31]}}, instr[31:20]};
                end
            end
            opc_store: begin
                if (funct3 == 3'b010) begin
                    mem_write   = 1'b1;
                    alu_src_imm = 1'b1;
                    imm         = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                end
            end
            opc_branch: begin
                if (funct3 == 3'b000 || funct3 == 3'b001) begin
                    branch    = 1'b1;
                    branch_ne = funct3[0];
                    imm       = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                end
            end
            opc_jal: begin
                jump        = 1'b1;
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = alu_pass_b;      // Link value rides in the immediate slot
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            opc_jalr: begin
                if (funct3 == 3'b000) begin
                    jump_reg    = 1'b1;
                    reg_write   = 1'b1;
                    alu_src_imm = 1'b1;
                    alu_op      = alu_pass_b;
                    imm         = {{20{instr[31]}}, instr[31:20]};
                end
            end
            default: ;
        endcase
    end

endmodule : control_unit

//--- design/reg_file.sv
module reg_file import definitions::*; (
    input  logic            clk,
    input  logic            rstN,
    input  regName_t        rs1,
    input  regName_t        rs2,
    input  regName_t        rd,
    input  logic            we,
    input  logic [XLEN-1:0] wdata,
    output logic [XLEN-1:0] rdata1,
    output logic [XLEN-1:0] rdata2
);

    logic [XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // Same-cycle write shows up on the read ports
    assign rdata1 = (rs1 == '0) ? '0 : (we && rs1 == rd) ? wdata : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : (we && rs2 == rd) ? wdata : regs[rs2];

endmodule : reg_file

//--- design/alu.sv
module alu import definitions::*; (
    input  alu_op_t         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] y
);

    always_comb begin
        case (op)
            alu_add:    y = a + b;
            alu_sub:    y = a - b;
            alu_and:    y = a & b;
            alu_or:     y = a | b;
            alu_xor:    y = a ^ b;
            alu_slt:    y = ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
            alu_pass_b: y = b;
            default:    y = '0;
        endcase
    end

endmodule : alu

//--- design/data_mem.sv
module data_mem import definitions::*; #(
    parameter int MEM_LATENCY = 3,
    parameter int DMEM_WORDS  = 256
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic            mem_read,
    input  logic            mem_write,
    input  logic [XLEN-1:0] mem_addr,
    input  logic [XLEN-1:0] mem_wdata,
    output logic            mem_ready,
    output logic [XLEN-1:0] mem_rdata
);

    localparam int AW = $clog2(DMEM_WORDS);

    logic [XLEN-1:0] mem [DMEM_WORDS];
    logic            busy;
    logic [3:0]      count;
    logic [AW-1:0]   idx;
    logic            finish;

    assign idx    = mem_addr[AW+1:2];   // Word address
    assign finish = busy && !mem_ready && count == 4'd1;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy      <= 1'b0;
            count     <= '0;
            mem_ready <= 1'b1;
        end else if (!busy) begin
            if (mem_read || mem_write) begin
                busy      <= 1'b1;
                count     <= 4'(MEM_LATENCY);
                mem_ready <= 1'b0;
            end
        end else if (!mem_ready) begin
            count <= count - 4'd1;
            if (count == 4'd1) mem_ready <= 1'b1;
        end else begin
            // Ready cycle, the finished request is still on the port
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (finish && mem_write) begin
            mem[idx] <= mem_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (finish) mem_rdata <= mem[idx];
    end

endmodule : data_mem

//--- design/riscv_core.sv
module riscv_core import definitions::*; #(
    parameter int MEM_LATENCY = 3,
    parameter int DMEM_WORDS  = 256
) (
    input  logic            clk,
    input  logic            rstN,
    input  logic [31:0]     imem_data,
    output logic [31:0]     imem_addr,
    output logic            retire_valid,
    output regName_t        retire_rd,
    output logic [XLEN-1:0] retire_value
);

    logic [31:0] pc, id_pc, id_instr, target;
    logic        taken, redirect;

    regName_t        id_rs1, id_rs2, id_rd;
    alu_op_t         id_alu_op;
    logic            id_alu_src_imm, id_reg_write, id_mem_read, id_mem_write;
    logic            id_branch, id_branch_ne, id_jump, id_jump_reg;
    logic [XLEN-1:0] id_imm, id_rdata1, id_rdata2;

    regName_t        ex_rs1, ex_rs2, ex_rd;
    alu_op_t         ex_alu_op;
    logic            ex_alu_src_imm, ex_reg_write, ex_mem_read, ex_mem_write;
    logic [XLEN-1:0] ex_rs1_val, ex_rs2_val, ex_imm, ex_a, ex_b, alu_y;

    logic            wb_reg_write;
    regName_t        wb_rd;
    logic [XLEN-1:0] wb_value;

    logic            if_id_write, pc_write, id_ex_hold, id_ex_bubble;
    logic            branch_go, jump_reg_go, mem_done, mem_ready;
    logic [XLEN-1:0] mem_rdata;

    function automatic logic [XLEN-1:0] wb_fwd(input regName_t rs, input logic [XLEN-1:0] value);
        return (wb_reg_write && wb_rd != '0 && wb_rd == rs) ? wb_value : value;
    endfunction

    assign imem_addr = pc;

    // IF
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc       <= '0;
            id_instr <= NOP_INSTR;
            id_pc    <= '0;
        end else begin
            if (pc_write) pc <= redirect ? target : pc + 32'd4;
            if (if_id_write) begin
                id_instr <= redirect ? NOP_INSTR : imem_data;   // Flush on taken
                id_pc    <= pc;
            end
        end
    end

    // ID
    control_unit u_ctrl (
        .instr(id_instr), .rs1(id_rs1), .rs2(id_rs2), .rd(id_rd), .alu_op(id_alu_op),
        .alu_src_imm(id_alu_src_imm), .reg_write(id_reg_write), .mem_read(id_mem_read),
        .mem_write(id_mem_write), .branch(id_branch), .branch_ne(id_branch_ne),
        .jump(id_jump), .jump_reg(id_jump_reg), .imm(id_imm)
    );

    // The register file bypass carries the WB result into ID
    reg_file u_regs (
        .clk(clk), .rstN(rstN), .rs1(id_rs1), .rs2(id_rs2), .rd(wb_rd),
        .we(wb_reg_write), .wdata(wb_value), .rdata1(id_rdata1), .rdata2(id_rdata2)
    );

    always_comb begin
        taken    = id_branch_ne ? (id_rdata1 != id_rdata2) : (id_rdata1 == id_rdata2);
        target   = jump_reg_go ? ((id_rdata1 + id_imm) & ~32'd1) : id_pc + id_imm;
        redirect = (id_jump && pc_write) || jump_reg_go || (branch_go && taken);
    end

    hazard_unit u_hazard (
        .clk(clk), .rstN(rstN), .rs1_id(id_rs1), .rs2_id(id_rs2), .rd_ex(ex_rd),
        .branch_cu(id_branch), .jump_reg_cu(id_jump_reg), .ex_mem_read(ex_mem_read),
        .ex_mem_write(ex_mem_write), .mem_ready(mem_ready), .reg_write_ex(ex_reg_write),
        .if_id_write(if_id_write), .pc_write(pc_write), .id_ex_hold(id_ex_hold),
        .id_ex_bubble(id_ex_bubble), .branch_go(branch_go), .jump_reg_go(jump_reg_go),
        .mem_done(mem_done)
    );

    // ID/EX
    always_ff @(posedge clk) begin
        if (!rstN || id_ex_bubble) begin
            ex_reg_write <= 1'b0;
            ex_mem_read  <= 1'b0;
            ex_mem_write <= 1'b0;
        end else if (!id_ex_hold) begin
            ex_reg_write <= id_reg_write;
            ex_mem_read  <= id_mem_read;
            ex_mem_write <= id_mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (id_ex_hold) begin
            // WB drains during the wait, so keep the forwarded operands
            ex_rs1_val <= ex_a;
            ex_rs2_val <= ex_b;
        end else begin
            ex_rs1         <= id_rs1;
            ex_rs2         <= id_rs2;
            ex_rd          <= id_rd;
            ex_alu_op      <= id_alu_op;
            ex_alu_src_imm <= id_alu_src_imm;
            ex_rs1_val     <= id_rdata1;
            ex_rs2_val     <= id_rdata2;
            ex_imm         <= (id_jump || id_jump_reg) ? id_pc + 32'd4 : id_imm;
        end
    end

    // EX
    always_comb begin
        ex_a = wb_fwd(ex_rs1, ex_rs1_val);
        ex_b = wb_fwd(ex_rs2, ex_rs2_val);
    end

    alu u_alu (.op(ex_alu_op), .a(ex_a), .b(ex_alu_src_imm ? ex_imm : ex_b), .y(alu_y));

    data_mem #(
        .MEM_LATENCY(MEM_LATENCY),
        .DMEM_WORDS (DMEM_WORDS)
    ) u_dmem (
        .clk(clk), .rstN(rstN), .mem_read(ex_mem_read), .mem_write(ex_mem_write),
        .mem_addr(alu_y), .mem_wdata(ex_b), .mem_ready(mem_ready), .mem_rdata(mem_rdata)
    );

    // EX/WB takes a bubble while EX waits on memory
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wb_reg_write <= 1'b0;
        end else begin
            wb_reg_write <= ex_reg_write && !id_ex_hold;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd    <= ex_rd;
        wb_value <= mem_done ? mem_rdata : alu_y;
    end

    assign retire_valid = wb_reg_write && wb_rd != '0;
    assign retire_rd    = wb_rd;
    assign retire_value = wb_value;

endmodule : riscv_core

//--- tests/core_tb.sv
module core_tb import definitions::*; ();

    localparam int LATENCY   = 3;
    localparam int ROM_WORDS = 64;
    localparam logic [31:0] NOP = 32'h0000_0013;   // addi x0, x0, 0

    logic            clk;
    logic            rstN;
    logic [31:0]     imem_data, imem_addr;
    logic            retire_valid;
    regName_t        retire_rd;
    logic [31:0]     retire_value;

    logic [31:0] rom [ROM_WORDS];
    int          prog_len;
    regName_t    exp_rd[$];
    logic [31:0] exp_val[$];
    int          ret_idx = 0;
    string       test_name;
    time         deadline = 0;
    logic [31:0] lfsr_state = 32'hf409d1be;

    riscv_core #(.MEM_LATENCY(LATENCY), .DMEM_WORDS(256)) UUT (
        .clk(clk), .rstN(rstN), .imem_data(imem_data), .imem_addr(imem_addr),
        .retire_valid(retire_valid), .retire_rd(retire_rd), .retire_value(retire_value)
    );

    // Past the ROM the core only sees no-ops
    assign imem_data = (imem_addr[31:8] == '0) ? rom[imem_addr[7:2]] : NOP;

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic lfsr_step();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) lfsr_state = lfsr_state ^ 32'h8020_0003;
        return b;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) v = (v << 1) | int'(lfsr_step());
        return v;
    endfunction

    function automatic logic [31:0] r_instr(input int f7, input int f3, input int rd,
                                            input int rs1, input int rs2);
        return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), opc_op};
    endfunction

    function automatic logic [31:0] i_instr(input opcode_t opc, input int f3, input int rd,
                                            input int rs1, input int imm);
        return {imm[11:0], 5'(rs1), 3'(f3), 5'(rd), opc};
    endfunction

    function automatic logic [31:0] sw_instr(input int rs2, input int rs1, input int imm);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], opc_store};
    endfunction

    function automatic logic [31:0] b_instr(input int f3, input int rs1, input int rs2,
                                            input int imm);
        return {imm[12], imm[10:5], 5'(rs2), 5'(rs1), 3'(f3), imm[4:1], imm[11], opc_branch};
    endfunction

    function automatic logic [31:0] lui_instr(input int rd, input int imm);
        return {imm[19:0], 5'(rd), opc_lui};
    endfunction

    function automatic logic [31:0] jal_instr(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], 5'(rd), opc_jal};
    endfunction

    // Sequential ISA model that fills the expected register-write list
    function automatic void run_model(input int len);
        logic [31:0] x [32];
        logic [31:0] dmem [256];
        logic [31:0] pc, next_pc, ins, a, b, val, addr, imm_i, imm_s, imm_b, imm_j;
        logic        wr;
        int          steps;
        for (int i = 0; i < 32; i++) x[i] = '0;
        for (int i = 0; i < 256; i++) dmem[i] = '0;
        exp_rd.delete();
        exp_val.delete();
        pc = '0;
        steps = 0;
        while (int'(pc >> 2) < len && steps < 1000) begin
            ins   = rom[pc[7:2]];
            a     = x[ins[19:15]];
            b     = x[ins[24:20]];
            imm_i = {{20{ins[31]}}, ins[31:20]};
            imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            wr = 1'b0;
            val = '0;
            next_pc = pc + 32'd4;
            case (ins[6:0])
                opc_op: begin
                    wr = 1'b1;
                    case ({ins[31:25], ins[14:12]})
                        10'b0000000_000: val = a + b;
                        10'b0100000_000: val = a - b;
                        10'b0000000_111: val = a & b;
                        10'b0000000_110: val = a | b;
                        10'b0000000_100: val = a ^ b;
                        10'b0000000_010: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                opc_op_imm: if (ins[14:12] == 3'b000) begin
                    wr = 1'b1;
                    val = a + imm_i;
                end
                opc_lui: begin
                    wr = 1'b1;
                    val = {ins[31:12], 12'b0};
                end
                opc_load: if (ins[14:12] == 3'b010) begin
                    addr = a + imm_i;
                    wr = 1'b1;
                    val = dmem[addr[9:2]];
                end
                opc_store: if (ins[14:12] == 3'b010) begin
                    addr = a + imm_s;
                    dmem[addr[9:2]] = b;
                end
                opc_branch: begin
                    if ((ins[14:12] == 3'b000 && a == b) || (ins[14:12] == 3'b001 && a != b))
                        next_pc = pc + imm_b;
                end
                opc_jal: begin
                    wr = 1'b1;
                    val = pc + 32'd4;
                    next_pc = pc + imm_j;
                end
                opc_jalr: if (ins[14:12] == 3'b000) begin
                    wr = 1'b1;
                    val = pc + 32'd4;
                    next_pc = (a + imm_i) & ~32'd1;
                end
                default: ;
            endcase
            if (wr && ins[11:7] != '0) begin
                x[ins[11:7]] = val;
                exp_rd.push_back(ins[11:7]);
                exp_val.push_back(val);
            end
            pc = next_pc;
            steps++;
        end
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic clear_rom();
        for (int i = 0; i < ROM_WORDS; i++) rom[i] = NOP;
        prog_len = 0;
    endtask

    task automatic emit(input logic [31:0] instr);
        rom[prog_len] = instr;
        prog_len++;
    endtask

    // Retire pulses are compared in order against the model
    initial begin
        forever begin
            @(negedge clk);
            if (retire_valid === 1'b1) begin
                if (ret_idx >= exp_rd.size()) begin
                    $display("Simulation FAILED");
                    $fatal(1, "%s: core retired more instructions than expected", test_name);
                end else begin
                    check({test_name, " rd"}, 32'(exp_rd[ret_idx]), 32'(retire_rd));
                    check({test_name, " value"}, exp_val[ret_idx], retire_value);
                    ret_idx++;
                end
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            if (deadline != 0 && $time > deadline) begin
                $display("Simulation FAILED");
                $fatal(1, "%s: core stopped retiring before the program finished", test_name);
            end
        end
    end

    task automatic run_test(input string name);
        test_name = name;
        rstN = 1'b0;
        run_model(prog_len);
        ret_idx = 0;
        deadline = $time + 64'(4 * 40 + prog_len * (LATENCY + 8) * 40);
        repeat (4) @(negedge clk);
        rstN = 1'b1;
        repeat (2) begin
            @(negedge clk);
            check({name, " early retire"}, 32'd0, 32'(retire_valid));
        end
        while (ret_idx < exp_rd.size()) @(negedge clk);
        repeat (12) @(negedge clk);   // Catch stray retires
    endtask

    task automatic build_random(input int len);
        int kind, rd, rs1, rs2;
        for (int i = 0; i < len; i++) begin
            kind = rand_bits(3);
            rd   = rand_bits(3);
            rs1  = rand_bits(3);
            rs2  = rand_bits(3);
            case (kind)
                0, 1, 2, 3: begin
                    case (rand_bits(3) % 6)
                        0: emit(r_instr(0, 0, rd, rs1, rs2));
                        1: emit(r_instr(32, 0, rd, rs1, rs2));
                        2: emit(r_instr(0, 7, rd, rs1, rs2));
                        3: emit(r_instr(0, 6, rd, rs1, rs2));
                        4: emit(r_instr(0, 4, rd, rs1, rs2));
                        default: emit(r_instr(0, 2, rd, rs1, rs2));
                    endcase
                end
                4: begin
                    if (rand_bits(1) == 1) begin
                        emit(i_instr(opc_op_imm, 0, rd, rs1, rand_bits(12) - 2048));
                    end else begin
                        emit(lui_instr(rd, rand_bits(20)));
                    end
                end
                5: emit(i_instr(opc_load, 2, rd, 0, rand_bits(4) * 4));
                6: emit(sw_instr(rs2, 0, rand_bits(4) * 4));
                default: emit(b_instr(rand_bits(1), rs1, rs2, (rand_bits(2) + 2) * 4));
            endcase
        end
    endtask

    initial begin
        rstN = 1'b0;
        clear_rom();
        emit(i_instr(opc_op_imm, 0, 1, 0, 5));
        emit(i_instr(opc_op_imm, 0, 2, 1, -3));
        emit(r_instr(0, 0, 3, 1, 2));
        emit(r_instr(32, 0, 4, 3, 1));
        emit(r_instr(0, 7, 5, 4, 1));
        emit(lui_instr(6, 'h12345));
        emit(r_instr(0, 4, 7, 6, 3));
        emit(r_instr(0, 6, 8, 7, 1));
        emit(i_instr(opc_op_imm, 0, 11, 0, -7));
        emit(r_instr(0, 2, 12, 11, 1));
        emit(r_instr(0, 2, 13, 1, 11));
        emit(i_instr(opc_op_imm, 0, 0, 1, 9));    // x0 stays zero
        emit(r_instr(0, 0, 14, 0, 1));
        run_test("alu chain");

        clear_rom();
        emit(i_instr(opc_op_imm, 0, 1, 0, 100));
        emit(i_instr(opc_op_imm, 0, 2, 0, 40));
        emit(sw_instr(1, 2, 0));
        emit(sw_instr(2, 2, 8));
        emit(i_instr(opc_load, 2, 3, 2, 0));
        emit(r_instr(0, 0, 4, 3, 3));
        emit(i_instr(opc_load, 2, 5, 2, 8));
        emit(sw_instr(5, 0, 4));
        emit(i_instr(opc_load, 2, 6, 0, 4));
        emit(i_instr(opc_op_imm, 0, 7, 6, 1));
        run_test("load store");

        clear_rom();
        emit(i_instr(opc_op_imm, 0, 1, 0, 3));
        emit(i_instr(opc_op_imm, 0, 2, 0, 3));
        emit(b_instr(0, 1, 2, 8));
        emit(i_instr(opc_op_imm, 0, 3, 0, 99));
        emit(i_instr(opc_op_imm, 0, 4, 0, 1));
        emit(b_instr(1, 1, 2, 8));
        emit(i_instr(opc_op_imm, 0, 5, 0, 2));
        emit(i_instr(opc_op_imm, 0, 6, 1, 1));
        emit(b_instr(1, 6, 1, 8));                  // Source from the previous instruction
        emit(i_instr(opc_op_imm, 0, 7, 0, 77));
        emit(b_instr(0, 6, 1, 8));
        emit(i_instr(opc_op_imm, 0, 8, 0, 8));
        run_test("branches");

        clear_rom();
        emit(jal_instr(1, 8));
        emit(i_instr(opc_op_imm, 0, 2, 0, 55));
        emit(i_instr(opc_op_imm, 0, 3, 0, 24));
        emit(i_instr(opc_jalr, 0, 5, 3, 0));
        emit(i_instr(opc_op_imm, 0, 6, 0, 66));
        emit(i_instr(opc_op_imm, 0, 7, 0, 77));
        emit(i_instr(opc_op_imm, 0, 8, 5, 1));
        emit(jal_instr(0, 8));
        emit(i_instr(opc_op_imm, 0, 9, 0, 99));
        emit(i_instr(opc_op_imm, 0, 10, 1, 0));
        run_test("jumps");

        for (int t = 0; t < 10; t++) begin
            clear_rom();
            build_random(24);
            run_test($sformatf("random %0d", t));
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule : core_tb

//--- riscv_core.f
design/definitions.sv
design/hazard_unit.sv
design/control_unit.sv
design/reg_file.sv
design/alu.sv
design/data_mem.sv
design/riscv_core.sv
tests/core_tb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
TOP       := core_tb
FILELIST  := riscv_core.f
LOG       := sim.log

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
